//--- design/gpu_pkg.sv
// frame geometry, fixed-point and fill constants, state, mode and register address types
package gpu_pkg;

    localparam int DATA_W    = 32;
    localparam int FRAC_BITS = 8;   // fraction bits of x, y and z

    localparam int FRAME_W      = 640;
    localparam int FRAME_H      = 480;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
    localparam int PIX_CNT_W    = $clog2(FRAME_PIXELS);
    localparam int WORD_BYTES   = 4;

    // fixed-point bounds of the visible frame
    localparam int X_LIMIT = FRAME_W << FRAC_BITS;
    localparam int Y_LIMIT = FRAME_H << FRAC_BITS;

    localparam logic [DATA_W-1:0] BG_COLOR  = 32'h0020_3020;   // rgb in the low 24 bits
    localparam logic [DATA_W-1:0] FAR_DEPTH = 32'h7FFF_FFFF;

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        DONE
    } gpu_state_e;

    // wide enough to sit in the mode register as is
    typedef enum logic [DATA_W-1:0] {
        MODE_NONE        = 32'd0,
        MODE_PLOT        = 32'd1,
        MODE_CLEAR_FRAME = 32'd2,
        MODE_CLEAR_DEPTH = 32'd3
    } gpu_mode_e;

    typedef enum logic [2:0] {
        PLOT_IDLE,
        Z_READ,
        Z_WAIT,
        RGB_WRITE,
        Z_WRITE
    } plot_state_e;

    typedef enum logic [3:0] {
        REG_FRAME_PTR = 4'd0,
        REG_START     = 4'd1,
        REG_DONE      = 4'd2,
        REG_ZBUF_PTR  = 4'd3,
        REG_COLOR     = 4'd4,
        REG_X         = 4'd5,
        REG_Y         = 4'd6,
        REG_Z         = 4'd7,
        REG_MODE      = 4'd8
    } reg_addr_e;

endpackage

//--- design/gpu_regs.sv
// host register slave holding the command registers and the done flag
`timescale 1ns/100ps

module gpu_regs import gpu_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              slave_chipselect,
    input  logic              slave_read,
    input  logic              slave_write,
    input  reg_addr_e         slave_address,
    input  logic [DATA_W-1:0] slave_writedata,
    output logic [DATA_W-1:0] slave_readdata,
    input  logic              done_set,
    output logic [DATA_W-1:0] frame_ptr,
    output logic [DATA_W-1:0] zbuf_ptr,
    output logic [DATA_W-1:0] color,
    output logic [DATA_W-1:0] x,
    output logic [DATA_W-1:0] y,
    output logic [DATA_W-1:0] z,
    output logic              start,
    output gpu_mode_e         mode
);

    logic done;
    logic wr_en;

    assign wr_en = slave_chipselect && slave_write;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_ptr <= '0;
            zbuf_ptr  <= '0;
            color     <= '0;
            x         <= '0;
            y         <= '0;
            z         <= '0;
            start     <= 1'b0;
            done      <= 1'b0;
            mode      <= MODE_NONE;
        end else begin
            if (wr_en) begin
                case (slave_address)
                    REG_FRAME_PTR: frame_ptr <= slave_writedata;
                    REG_START:     start     <= slave_writedata[0];
                    REG_ZBUF_PTR:  zbuf_ptr  <= slave_writedata;
                    REG_COLOR:     color     <= slave_writedata;
                    REG_X:         x         <= slave_writedata;
                    REG_Y:         y         <= slave_writedata;
                    REG_Z:         z         <= slave_writedata;
                    REG_MODE:      mode      <= gpu_mode_e'(slave_writedata);
                    default:       ;
                endcase
            end
            // controller beats a host write to done
            if (done_set)
                done <= 1'b1;
            else if (wr_en && slave_address == REG_DONE)
                done <= slave_writedata[0];
        end
    end

    always_comb begin
        slave_readdata = '0;
        if (slave_chipselect && slave_read) begin
            case (slave_address)
                REG_FRAME_PTR: slave_readdata = frame_ptr;
                REG_START:     slave_readdata = {{(DATA_W-1){1'b0}}, start};
                REG_DONE:      slave_readdata = {{(DATA_W-1){1'b0}}, done};
                REG_ZBUF_PTR:  slave_readdata = zbuf_ptr;
                REG_COLOR:     slave_readdata = color;
                REG_X:         slave_readdata = x;
                REG_Y:         slave_readdata = y;
                REG_Z:         slave_readdata = z;
                REG_MODE:      slave_readdata = mode;
                default:       slave_readdata = '0;   // unmapped slots
            endcase
        end
    end

endmodule

//--- design/gpu_ctrl.sv
// command state machine launching the selected engine and routing its bus requests
`timescale 1ns/100ps

module gpu_ctrl import gpu_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              start,
    input  gpu_mode_e         mode,
    input  logic              clear_done,
    input  logic              plot_done,
    input  logic              clear_read,
    input  logic              clear_write,
    input  logic [DATA_W-1:0] clear_address,
    input  logic [DATA_W-1:0] clear_writedata,
    input  logic              plot_read,
    input  logic              plot_write,
    input  logic [DATA_W-1:0] plot_address,
    input  logic [DATA_W-1:0] plot_writedata,
    output logic              clear_go,
    output logic              plot_go,
    output logic              done_set,
    output logic              master_chipselect,
    output logic              master_read,
    output logic              master_write,
    output logic [DATA_W-1:0] master_address,
    output logic [DATA_W-1:0] master_writedata
);

    gpu_state_e state, state_next;
    logic       engine_done;

    always_comb begin
        state_next  = state;
        clear_go    = 1'b0;
        plot_go     = 1'b0;
        done_set    = 1'b0;
        engine_done = 1'b0;

        case (mode)
            MODE_PLOT:                         engine_done = plot_done;
            MODE_CLEAR_FRAME, MODE_CLEAR_DEPTH: engine_done = clear_done;
            default:                           engine_done = 1'b0;
        endcase

        case (state)
            IDLE: begin
                if (start) begin
                    state_next = RUNNING;
                    case (mode)
                        MODE_PLOT:                         plot_go  = 1'b1;
                        MODE_CLEAR_FRAME, MODE_CLEAR_DEPTH: clear_go = 1'b1;
                        default: begin
                            // nothing to run
                            state_next = DONE;
                            done_set   = 1'b1;
                        end
                    endcase
                end
            end
            RUNNING: begin
                if (engine_done) begin
                    state_next = DONE;
                    done_set   = 1'b1;
                end
            end
            DONE: begin
                if (!start)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            state <= IDLE;
        else
            state <= state_next;
    end

    // bus goes to whichever engine mode picked
    always_comb begin
        master_read      = 1'b0;
        master_write     = 1'b0;
        master_address   = '0;
        master_writedata = '0;
        if (state == RUNNING) begin
            case (mode)
                MODE_PLOT: begin
                    master_read      = plot_read;
                    master_write     = plot_write;
                    master_address   = plot_address;
                    master_writedata = plot_writedata;
                end
                MODE_CLEAR_FRAME, MODE_CLEAR_DEPTH: begin
                    master_read      = clear_read;
                    master_write     = clear_write;
                    master_address   = clear_address;
                    master_writedata = clear_writedata;
                end
                default: ;
            endcase
        end
        master_chipselect = master_read || master_write;
    end

endmodule

//--- design/buffer_clear.sv
// fill engine writing the frame or depth buffer one word per accepted write
`timescale 1ns/100ps

module buffer_clear import gpu_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              clear_go,
    input  gpu_mode_e         mode,
    input  logic [DATA_W-1:0] frame_ptr,
    input  logic [DATA_W-1:0] zbuf_ptr,
    input  logic              master_waitrequest,
    output logic              clear_read,
    output logic              clear_write,
    output logic [DATA_W-1:0] clear_address,
    output logic [DATA_W-1:0] clear_writedata,
    output logic              clear_done
);

    logic                 active;
    logic                 fill_depth;
    logic [PIX_CNT_W-1:0] count;
    logic [DATA_W-1:0]    addr;
    logic                 accept;

    assign accept = active && !master_waitrequest;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active     <= 1'b0;
            count      <= '0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            if (clear_go) begin
                active <= 1'b1;
                count  <= '0;
            end else if (accept) begin
                count <= count + 1'b1;
                if (count == PIX_CNT_W'(FRAME_PIXELS - 1)) begin
                    active     <= 1'b0;
                    clear_done <= 1'b1;   // cycle after the last accept
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (clear_go) begin
            fill_depth <= (mode == MODE_CLEAR_DEPTH);
            addr       <= (mode == MODE_CLEAR_DEPTH) ? zbuf_ptr : frame_ptr;
        end else if (accept) begin
            addr <= addr + DATA_W'(WORD_BYTES);
        end
    end

    assign clear_read      = 1'b0;   // write only engine
    assign clear_write     = active;
    assign clear_address   = addr;
    assign clear_writedata = fill_depth ? FAR_DEPTH : BG_COLOR;

endmodule

//--- design/point_plot.sv
// single fragment engine doing bounds check, depth read, colour write and depth write
`timescale 1ns/100ps

module point_plot import gpu_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              plot_go,
    input  logic [DATA_W-1:0] frame_ptr,
    input  logic [DATA_W-1:0] zbuf_ptr,
    input  logic [DATA_W-1:0] color,
    input  logic [DATA_W-1:0] x,
    input  logic [DATA_W-1:0] y,
    input  logic [DATA_W-1:0] z,
    input  logic              master_waitrequest,
    input  logic [DATA_W-1:0] master_readdata,
    input  logic              master_readdatavalid,
    output logic              plot_read,
    output logic              plot_write,
    output logic [DATA_W-1:0] plot_address,
    output logic [DATA_W-1:0] plot_writedata,
    output logic              plot_done
);

    plot_state_e       state;
    logic              in_bounds;
    logic [DATA_W-1:0] pix_idx;
    logic [DATA_W-1:0] pix_off;

    // latched fragment
    logic [DATA_W-1:0] rgb_addr;
    logic [DATA_W-1:0] z_addr;
    logic [DATA_W-1:0] frag_z;
    logic [23:0]       frag_rgb;

    assign in_bounds = ($signed(x) > 0) && ($signed(x) < X_LIMIT)
                    && ($signed(y) > 0) && ($signed(y) < Y_LIMIT);

    assign pix_idx = (y >> FRAC_BITS) * FRAME_W + (x >> FRAC_BITS);
    assign pix_off = pix_idx * WORD_BYTES;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= PLOT_IDLE;
            plot_done <= 1'b0;
        end else begin
            plot_done <= 1'b0;
            case (state)
                PLOT_IDLE: begin
                    if (plot_go) begin
                        if (in_bounds)
                            state <= Z_READ;
                        else
                            plot_done <= 1'b1;   // off screen, no bus access
                    end
                end
                Z_READ: begin
                    if (!master_waitrequest)
                        state <= Z_WAIT;
                end
                Z_WAIT: begin
                    if (master_readdatavalid) begin
                        if ($signed(master_readdata) > $signed(frag_z)) begin
                            state <= RGB_WRITE;
                        end else begin
                            state     <= PLOT_IDLE;
                            plot_done <= 1'b1;
                        end
                    end
                end
                RGB_WRITE: begin
                    if (!master_waitrequest)
                        state <= Z_WRITE;
                end
                Z_WRITE: begin
                    if (!master_waitrequest) begin
                        state     <= PLOT_IDLE;
                        plot_done <= 1'b1;
                    end
                end
                default: state <= PLOT_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == PLOT_IDLE && plot_go) begin
            rgb_addr <= frame_ptr + pix_off;
            z_addr   <= zbuf_ptr + pix_off;
            frag_z   <= z;
            frag_rgb <= color[23:0];
        end
    end

    assign plot_read      = (state == Z_READ);
    assign plot_write     = (state == RGB_WRITE) || (state == Z_WRITE);
    assign plot_address   = (state == RGB_WRITE) ? rgb_addr : z_addr;
    assign plot_writedata = (state == RGB_WRITE) ? {8'h00, frag_rgb} : frag_z;

endmodule

//--- design/gpu_core.sv
// top level joining the register slave, command controller and the two engines
`timescale 1ns/100ps

module gpu_core import gpu_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              slave_chipselect,
    input  logic              slave_read,
    input  logic              slave_write,
    input  reg_addr_e         slave_address,
    input  logic [DATA_W-1:0] slave_writedata,
    output logic [DATA_W-1:0] slave_readdata,
    output logic              master_chipselect,
    output logic              master_read,
    output logic              master_write,
    output logic [DATA_W-1:0] master_address,
    output logic [DATA_W-1:0] master_writedata,
    input  logic [DATA_W-1:0] master_readdata,
    input  logic              master_readdatavalid,
    input  logic              master_waitrequest
);

    logic [DATA_W-1:0] frame_ptr, zbuf_ptr, color, x, y, z;
    logic              start;
    gpu_mode_e         mode;
    logic              done_set;

    logic              clear_go, clear_done;
    logic              clear_read, clear_write;
    logic [DATA_W-1:0] clear_address, clear_writedata;

    logic              plot_go, plot_done;
    logic              plot_read, plot_write;
    logic [DATA_W-1:0] plot_address, plot_writedata;

    gpu_regs i_gpu_regs (
        .CLK, .RESET,
        .slave_chipselect, .slave_read, .slave_write, .slave_address,
        .slave_writedata, .slave_readdata, .done_set,
        .frame_ptr, .zbuf_ptr, .color, .x, .y, .z, .start, .mode
    );

    gpu_ctrl i_gpu_ctrl (
        .CLK, .RESET, .start, .mode, .clear_done, .plot_done,
        .clear_read, .clear_write, .clear_address, .clear_writedata,
        .plot_read, .plot_write, .plot_address, .plot_writedata,
        .clear_go, .plot_go, .done_set,
        .master_chipselect, .master_read, .master_write,
        .master_address, .master_writedata
    );

    buffer_clear i_buffer_clear (
        .CLK, .RESET, .clear_go, .mode, .frame_ptr, .zbuf_ptr, .master_waitrequest,
        .clear_read, .clear_write, .clear_address, .clear_writedata, .clear_done
    );

    point_plot i_point_plot (
        .CLK, .RESET, .plot_go, .frame_ptr, .zbuf_ptr, .color, .x, .y, .z,
        .master_waitrequest, .master_readdata, .master_readdatavalid,
        .plot_read, .plot_write, .plot_address, .plot_writedata, .plot_done
    );

endmodule

//--- tests/gpu_core_props.sv
// bus master assertions bound into the gpu core
`timescale 1ns/100ps

module gpu_core_props import gpu_pkg::*; (
    input logic              CLK,
    input logic              RESET,
    input logic              master_chipselect,
    input logic              master_read,
    input logic              master_write,
    input logic [DATA_W-1:0] master_address,
    input logic [DATA_W-1:0] master_writedata,
    input logic              master_waitrequest
);

    // one direction per transfer
    read_write_exclusive: assert property (
        @(posedge CLK) disable iff (RESET) !(master_read && master_write)
    ) else $error("master read and write high together");

    // stalled request keeps strobe, address and data
    request_held: assert property (
        @(posedge CLK) disable iff (RESET)
        (master_read || master_write) && master_waitrequest |=>
            $stable(master_read) && $stable(master_write)
            && $stable(master_address) && $stable(master_writedata)
    ) else $error("master request changed under waitrequest");

    chipselect_match: assert property (
        @(posedge CLK) disable iff (RESET) master_chipselect == (master_read || master_write)
    ) else $error("master chipselect differs from read or write");

endmodule

bind gpu_core gpu_core_props i_gpu_core_props (.*);

//--- tests/tb_gpu_core.sv
// testbench with clock, reset, stalling memory model, directed tests, compare tasks and timeout
`timescale 1ns/100ps

module tb_gpu_core import gpu_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int CYCLE_LIMIT = 4 * (2 * FRAME_PIXELS + 100);   // worst case 4 cycles per accept

    localparam logic [DATA_W-1:0] FRAME_BASE = 32'h0100_0000;
    localparam logic [DATA_W-1:0] ZBUF_BASE  = 32'h0200_0000;

    // fragment for the plot tests, pixel (100, 50)
    localparam logic [DATA_W-1:0] PX     = 32'h0000_6480;
    localparam logic [DATA_W-1:0] PY     = 32'h0000_3240;
    localparam logic [DATA_W-1:0] PZ     = 32'h0000_1000;
    localparam logic [DATA_W-1:0] PCOLOR = 32'hff12_3456;
    localparam int                PIX    = 50 * FRAME_W + 100;

    logic              CLK;
    logic              RESET;
    logic              slave_chipselect, slave_read, slave_write;
    reg_addr_e         slave_address;
    logic [DATA_W-1:0] slave_writedata, slave_readdata;
    logic              master_chipselect, master_read, master_write;
    logic [DATA_W-1:0] master_address, master_writedata, master_readdata;
    logic              master_readdatavalid, master_waitrequest;

    logic [DATA_W-1:0] mem [logic [DATA_W-1:0]];
    logic [DATA_W-1:0] wr_addr_q [$];
    logic [DATA_W-1:0] wr_data_q [$];
    int                read_count;
    logic [31:0]       rng;
    int                cycles;

    gpu_core i_gpu_core (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // memory slave, decides at the falling edge what the next rising edge accepts
    initial begin
        int                pending;
        int                stall_run;
        logic [DATA_W-1:0] rd_addr;
        pending              = 0;
        stall_run            = 0;
        rd_addr              = '0;
        read_count           = 0;
        rng                  = 32'h4192c7ac;
        master_waitrequest   = 1'b0;
        master_readdatavalid = 1'b0;
        master_readdata      = '0;
        forever begin
            @(negedge CLK);
            master_readdatavalid = 1'b0;
            if (pending > 0) begin
                pending--;
                if (pending == 0) begin
                    master_readdatavalid = 1'b1;
                    master_readdata      = mem.exists(rd_addr) ? mem[rd_addr] : '0;
                end
            end
            rng = xorshift(rng);
            if (stall_run < 3 && rng[1:0] == 2'b00) begin
                master_waitrequest = 1'b1;
                stall_run++;
            end else begin
                master_waitrequest = 1'b0;
                stall_run          = 0;
            end
            if (master_chipselect && !master_waitrequest) begin
                if (master_write) begin
                    mem[master_address] = master_writedata;
                    wr_addr_q.push_back(master_address);
                    wr_data_q.push_back(master_writedata);
                end
                if (master_read) begin
                    read_count++;
                    rd_addr = master_address;
                    rng     = xorshift(rng);
                    pending = 1 + int'(rng % 32'd3);   // 1 to 3 cycles
                end
            end
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [DATA_W-1:0] got, exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic verify_mode(input string name, input gpu_mode_e got, exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp)
            stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic expect_count(input string what, input int got, exp);
        if (got != exp)
            stop_run($sformatf("%s: saw %0d, expected %0d", what, got, exp));
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [DATA_W-1:0] data);
        @(negedge CLK);
        slave_chipselect = 1'b1;
        slave_write      = 1'b1;
        slave_address    = addr;
        slave_writedata  = data;
        @(negedge CLK);
        slave_chipselect = 1'b0;
        slave_write      = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [DATA_W-1:0] data);
        @(negedge CLK);
        slave_chipselect = 1'b1;
        slave_read       = 1'b1;
        slave_address    = addr;
        @(negedge CLK);
        data             = slave_readdata;   // held a full cycle by now
        slave_chipselect = 1'b0;
        slave_read       = 1'b0;
    endtask

    task automatic readback(input string name, input reg_addr_e addr,
                            input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] d;
        read_reg(addr, d);
        compare_word(name, d, exp);
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] d;
        d = '0;
        while (d[0] !== 1'b1)
            read_reg(REG_DONE, d);
    endtask

    task automatic run_command(input gpu_mode_e m);
        write_reg(REG_MODE, m);
        write_reg(REG_START, 32'd1);
        wait_done();
        write_reg(REG_START, 32'd0);   // back to idle
        write_reg(REG_DONE, 32'd0);
    endtask

    task automatic load_fragment(input logic [DATA_W-1:0] fx, fy, fz);
        write_reg(REG_COLOR, PCOLOR);
        write_reg(REG_X, fx);
        write_reg(REG_Y, fy);
        write_reg(REG_Z, fz);
    endtask

    task automatic register_readback();
        logic [DATA_W-1:0] d;
        int                first;
        write_reg(REG_FRAME_PTR, 32'h1111_0000);
        write_reg(REG_ZBUF_PTR, 32'h2222_0004);
        write_reg(REG_COLOR, 32'h00a1_b2c3);
        write_reg(REG_X, 32'h0000_1234);
        write_reg(REG_Y, 32'h0000_5678);
        write_reg(REG_Z, 32'h0000_9abc);
        write_reg(REG_MODE, MODE_CLEAR_DEPTH);
        write_reg(REG_START, 32'd0);
        readback("frame_ptr", REG_FRAME_PTR, 32'h1111_0000);
        readback("zbuf_ptr", REG_ZBUF_PTR, 32'h2222_0004);
        readback("color", REG_COLOR, 32'h00a1_b2c3);
        readback("x", REG_X, 32'h0000_1234);
        readback("y", REG_Y, 32'h0000_5678);
        readback("z", REG_Z, 32'h0000_9abc);
        read_reg(REG_MODE, d);
        verify_mode("mode", gpu_mode_e'(d), MODE_CLEAR_DEPTH);
        read_reg(REG_START, d);
        check_flag("start", d[0], 1'b0);
        // undefined mode finishes at once without touching memory
        first = wr_addr_q.size();
        run_command(MODE_NONE);
        read_reg(REG_DONE, d);
        check_flag("done", d[0], 1'b0);
        expect_count("writes for an empty command", wr_addr_q.size() - first, 0);
    endtask

    task automatic buffer_fill(input gpu_mode_e m, input logic [DATA_W-1:0] base, fill);
        int first;
        int reads;
        write_reg(REG_FRAME_PTR, FRAME_BASE);
        write_reg(REG_ZBUF_PTR, ZBUF_BASE);
        first = wr_addr_q.size();
        reads = read_count;
        run_command(m);
        expect_count("clear writes", wr_addr_q.size() - first, FRAME_PIXELS);
        expect_count("clear reads", read_count - reads, 0);
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            compare_word("master_address", wr_addr_q[first + i], base + WORD_BYTES * i);
            compare_word("master_writedata", wr_data_q[first + i], fill);
        end
    endtask

    task automatic plot_pass();
        int first;
        int reads;
        load_fragment(PX, PY, PZ);
        first = wr_addr_q.size();
        reads = read_count;
        run_command(MODE_PLOT);
        expect_count("plot writes", wr_addr_q.size() - first, 2);
        expect_count("plot reads", read_count - reads, 1);
        compare_word("master_address", wr_addr_q[first], FRAME_BASE + WORD_BYTES * PIX);
        compare_word("master_address", wr_addr_q[first + 1], ZBUF_BASE + WORD_BYTES * PIX);
        compare_word("frame word", mem[FRAME_BASE + WORD_BYTES * PIX], {8'h00, PCOLOR[23:0]});
        compare_word("depth word", mem[ZBUF_BASE + WORD_BYTES * PIX], PZ);
    endtask

    task automatic rejected_plot(input logic [DATA_W-1:0] fx, fy, fz, input int exp_reads);
        int first;
        int reads;
        load_fragment(fx, fy, fz);
        first = wr_addr_q.size();
        reads = read_count;
        run_command(MODE_PLOT);
        expect_count("rejected plot writes", wr_addr_q.size() - first, 0);
        expect_count("rejected plot reads", read_count - reads, exp_reads);
    endtask

    task automatic plot_reject();
        rejected_plot(PX, PY, PZ + 32'h1000, 1);   // farther than stored depth
        compare_word("depth word", mem[ZBUF_BASE + WORD_BYTES * PIX], PZ);
        rejected_plot(32'd0, PY, PZ, 0);
        rejected_plot(PX, FRAME_H << FRAC_BITS, PZ, 0);
    endtask

    initial begin
        RESET            = 1'b1;
        slave_chipselect = 1'b0;
        slave_read       = 1'b0;
        slave_write      = 1'b0;
        slave_address    = REG_FRAME_PTR;
        slave_writedata  = '0;
        repeat (10) @(negedge CLK);
        RESET = 1'b0;
        register_readback();
        buffer_fill(MODE_CLEAR_FRAME, FRAME_BASE, BG_COLOR);
        buffer_fill(MODE_CLEAR_DEPTH, ZBUF_BASE, FAR_DEPTH);
        plot_pass();
        plot_reject();
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: simulation ran too long");
        $display("FAIL: see errors above");
        $fatal(1);
    end

endmodule

//--- gpu_core.f
design/gpu_pkg.sv
design/gpu_regs.sv
design/gpu_ctrl.sv
design/buffer_clear.sv
design/point_plot.sv
design/gpu_core.sv
tests/gpu_core_props.sv
tests/tb_gpu_core.sv

//--- Makefile
# Verilator build and run of the gpu core testbench

VERILATOR ?= verilator
TOP       ?= tb_gpu_core
FILELIST  ?= gpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qxF "PASS: all tests" $(LOG) && echo "test passed" || { echo "test failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
